/* sim.f */
source/slam_cfg_pkg.sv
source/cb_map_pkg.sv
source/cb_bank_mem.sv
source/cb_row_counter.sv
source/cb_read_fsm.sv
source/cb_douta_map.sv
source/cb_read_top.sv
sim/tb_clk_gen.sv
sim/cb_read_sva.sv
sim/tb_cb_read.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the CB read path testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_cb_read -f sim.f -o sim_cb_read

out=$(./obj_dir/sim_cb_read +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1

/* sim/tb_cb_read.sv */
`timescale 1ns/1ps

module tb_cb_read import slam_cfg_pkg::*, cb_map_pkg::*; ();

  localparam logic [31:0] SEED     = 32'hb42427b9;
  localparam int          WAIT_MAX = 20; // cycles allowed before the first valid.

  logic        clk;
  logic        sys_rst;
  logic        wr_stb;
  cb_wr_t      wr;
  logic        cmd_stb;
  cb_cmd_t     cmd;
  logic        busy;
  logic        valid;
  logic        done;
  cb_map_out_t map_out;

  cb_row_t     shadow [CB_DEPTH]; // copy of every loaded row.
  logic [31:0] rng;
  int          errors = 0;
  int          checks = 0;
  int          valid_total = 0;
  int          accepted_rows = 0;

  tb_clk_gen u_clk (.clk(clk), .sys_rst(sys_rst));

  cb_read_top u_dut (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_wr_stb  (wr_stb),
    .i_wr      (wr),
    .i_cmd_stb (cmd_stb),
    .i_cmd     (cmd),
    .o_busy    (busy),
    .o_valid   (valid),
    .o_done    (done),
    .o_map     (map_out)
  );

  // the top level holds both the sequencer and the mapper signals.
  bind cb_read_top cb_read_sva u_sva (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_accept   (cnt_clr),
    .i_rd_en    (rd_en),
    .i_sel      (map_sel),
    .i_l_k_0    (map_l_k_0),
    .i_pos      (map_pos),
    .i_row      (rd_data),
    .i_map      (o_map),
    .i_valid    (o_valid),
    .i_done     (o_done)
  );

  always @(negedge clk) begin
    if (!sys_rst && valid) valid_total++;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cb_cmd_t make_cmd(input cb_dest_e dest, input cb_dir_e dir,
                                       input logic lk, input int base, input int count);
    cb_cmd_t c;
    c.sel.dest = dest;
    c.sel.dir  = dir;
    c.l_k_0    = lk;
    c.base     = ROW_LEN'(base);
    c.count    = ROW_LEN'(count); // rows minus one.
    return c;
  endfunction

  function automatic cb_row_t operand_lanes(input cb_dir_e dir, input logic lk, input cb_row_t row);
    case (dir)
      DIR_POS: return row;
      DIR_NEG: return {row[0], row[1], row[2], row[3]};
      DIR_NEW: return lk ? {32'h0, row[1], row[0]} : {32'h0, row[3], row[2]};
      default: return '0;
    endcase
  endfunction

  // temp buffer placement table, pair chosen by l_k_0.
  function automatic cb_row_t tb_lanes(input logic lk, input int pos, input cb_row_t row);
    logic [RSA_DW-1:0] lo;
    logic [RSA_DW-1:0] hi;
    lo = lk ? row[0] : row[2];
    hi = lk ? row[1] : row[3];
    case (pos)
      0: return {hi, 48'h0};
      1: return {48'h0, lo};
      2: return {32'h0, lo, hi};
      3: return {16'h0, lo, hi, 16'h0};
      4: return {lo, hi, 32'h0};
      default: return '0;
    endcase
  endfunction

  function automatic cb_map_out_t expected_map(input cb_sel_t sel, input logic lk,
                                               input int pos, input cb_row_t row);
    cb_map_out_t res;
    res = '0;
    case (sel.dest)
      DEST_TB: res.tb = (sel.dir == DIR_NEW) ? tb_lanes(lk, pos, row) : '0;
      DEST_A:  res.a  = operand_lanes(sel.dir, lk, row);
      DEST_B:  res.b  = operand_lanes(sel.dir, lk, row);
      DEST_M:  res.m  = operand_lanes(sel.dir, lk, row);
    endcase
    return res;
  endfunction

  task automatic check_map(input string name, input cb_map_out_t exp, input cb_map_out_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic load_rows(input int n);
    cb_wr_t w;
    for (int i = 0; i < n; i++) begin
      rng = lcg_next(rng);
      w.row[1:0] = rng;
      rng = lcg_next(rng);
      w.row[3:2] = rng;
      w.addr = ROW_LEN'(i);
      shadow[w.addr] = w.row;
      wr = w;
      wr_stb = 1'b1;
      @(posedge clk);
      #1;
    end
    wr_stb = 1'b0;
  endtask

  task automatic send_cmd(input cb_cmd_t c);
    @(posedge clk);
    #1;
    cmd = c;
    cmd_stb = 1'b1;
    @(posedge clk);
    #1;
    cmd_stb = 1'b0;
  endtask

  task automatic collect_run(input string name, input cb_cmd_t c);
    int                 waited;
    int                 pos;
    logic [ROW_LEN-1:0] addr;
    waited = 0;
    pos = 0;
    @(negedge clk);
    while (!valid && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (!valid) begin
      errors++;
      $display("%s: timed out waiting for valid output", name);
    end
    // one row per cycle, bounded by the run length.
    while (valid && pos <= int'(c.count)) begin
      addr = c.base + ROW_LEN'(pos);
      check_map(name, expected_map(c.sel, c.l_k_0, pos, shadow[addr]), map_out);
      check_flag({name, " done"}, pos == int'(c.count), done);
      pos++;
      @(negedge clk);
    end
    check_flag({name, " valid end"}, 1'b0, valid);
    if (pos != int'(c.count) + 1) begin
      errors++;
      $display("** Error %s rows expected %0d actual %0d", name, int'(c.count) + 1, pos);
    end
  endtask

  task automatic run_cmd(input string name, input cb_cmd_t c);
    send_cmd(c);
    collect_run(name, c);
    accepted_rows += int'(c.count) + 1;
  endtask

  initial begin
    cb_dest_e ports [3];
    cb_cmd_t  first;
    int       waited;
    int       sva_fails;
    ports = '{DEST_A, DEST_B, DEST_M};
    wr_stb = 1'b0;
    wr = '0;
    cmd_stb = 1'b0;
    cmd = '0;
    rng = SEED;
    waited = 0;
    @(posedge clk);
    while (sys_rst && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (sys_rst) begin
      errors++;
      $display("reset was never released");
    end
    @(negedge clk);
    check_map("reset map", '0, map_out);
    check_flag("reset valid", 1'b0, valid);
    check_flag("reset done", 1'b0, done);
    check_flag("reset busy", 1'b0, busy);
    @(posedge clk);
    #1;
    load_rows(32);

    run_cmd("idle_dir", make_cmd(DEST_A, DIR_IDLE, 1'b0, 0, 2));
    foreach (ports[i]) begin
      run_cmd($sformatf("pos_%s", ports[i].name()), make_cmd(ports[i], DIR_POS, 1'b0, 4, 3));
      run_cmd($sformatf("neg_%s", ports[i].name()), make_cmd(ports[i], DIR_NEG, 1'b0, 8, 3));
      for (int lk = 0; lk < 2; lk++) begin
        run_cmd($sformatf("new_%s_lk%0d", ports[i].name(), lk),
                make_cmd(ports[i], DIR_NEW, lk[0], 12, 1));
      end
    end
    for (int lk = 0; lk < 2; lk++) begin
      run_cmd($sformatf("tb_new_lk%0d", lk), make_cmd(DEST_TB, DIR_NEW, lk[0], 16, 5));
    end
    run_cmd("tb_pos", make_cmd(DEST_TB, DIR_POS, 1'b1, 16, 1));

    // second strobe lands while the first run is still reading.
    first = make_cmd(DEST_M, DIR_POS, 1'b0, 20, 7);
    send_cmd(first);
    check_flag("busy_drop busy", 1'b1, busy);
    cmd = make_cmd(DEST_A, DIR_NEG, 1'b0, 0, 3);
    cmd_stb = 1'b1;
    @(posedge clk);
    #1;
    cmd_stb = 1'b0;
    collect_run("busy_drop", first);
    accepted_rows += int'(first.count) + 1;

    repeat (4) @(negedge clk);
    checks++;
    if (valid_total != accepted_rows) begin
      errors++;
      $display("** Error valid_cycles expected %0d actual %0d", accepted_rows, valid_total);
    end
    sva_fails = u_dut.u_sva.fail_cnt;
    $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/cb_read_sva.sv */
`timescale 1ns/1ps

module cb_read_sva import slam_cfg_pkg::*, cb_map_pkg::*; (
  input logic               clk,
  input logic               sys_rst,
  input logic               i_accept, // command taken by the sequencer.
  input logic               i_rd_en,
  input cb_sel_t            i_sel,
  input logic               i_l_k_0,
  input logic [ROW_LEN-1:0] i_pos,
  input cb_row_t            i_row,
  input cb_map_out_t        i_map,
  input logic               i_valid,
  input logic               i_done
);

  int fail_cnt = 0; // assertion failures so far.

  task automatic count_failure(input string what);
    fail_cnt++;
    $error("%s", what);
  endtask

  // what one port should carry for the row the mapper took in.
  function automatic cb_row_t expect_port(
    input cb_sel_t            s,
    input cb_dest_e           port,
    input logic               lk,
    input logic [ROW_LEN-1:0] p,
    input cb_row_t            row
  );
    cb_row_t res;
    res = '0;
    if (s.dest == port && port != DEST_TB) begin
      for (int i = 0; i < L_LANES; i++) begin
        if (s.dir == DIR_POS) res[i] = row[i];
        if (s.dir == DIR_NEG) res[i] = row[L_LANES-1-i];
      end
      if (s.dir == DIR_NEW) begin
        for (int i = 0; i < 2; i++) begin
          res[i] = lk ? row[i] : row[i+2];
        end
      end
    end else if (s.dest == port && s.dir == DIR_NEW && p < ROW_LEN'(TB_NEW_STEPS)) begin
      // low element sits one lane above the high one, both step with the position.
      for (int i = 0; i < L_LANES; i++) begin
        if (i == (int'(p) + 4) % 5) res[i] = lk ? row[0] : row[2];
        if (i == (int'(p) + 3) % 5) res[i] = lk ? row[1] : row[3];
      end
    end
    return res;
  endfunction

  a_tb_port: assert property (@(posedge clk) disable iff (sys_rst)
    i_map.tb == expect_port($past(i_sel), DEST_TB, $past(i_l_k_0), $past(i_pos), $past(i_row)))
    else count_failure("tb port differs from the mapping rule");

  a_a_port: assert property (@(posedge clk) disable iff (sys_rst)
    i_map.a == expect_port($past(i_sel), DEST_A, $past(i_l_k_0), $past(i_pos), $past(i_row)))
    else count_failure("a port differs from the mapping rule");

  a_b_port: assert property (@(posedge clk) disable iff (sys_rst)
    i_map.b == expect_port($past(i_sel), DEST_B, $past(i_l_k_0), $past(i_pos), $past(i_row)))
    else count_failure("b port differs from the mapping rule");

  a_m_port: assert property (@(posedge clk) disable iff (sys_rst)
    i_map.m == expect_port($past(i_sel), DEST_M, $past(i_l_k_0), $past(i_pos), $past(i_row)))
    else count_failure("m port differs from the mapping rule");

  // memory stage plus mapper stage after each read issue.
  a_valid_lag: assert property (@(posedge clk) disable iff (sys_rst)
    i_valid == $past(i_rd_en, 2))
    else count_failure("valid is not two cycles behind the read issue");

  a_valid_after_cmd: assert property (@(posedge clk) disable iff (sys_rst)
    $past(i_accept, 3) |-> i_valid)
    else count_failure("accepted command gave no valid output");

  // done marks the last row of an unbroken valid run.
  a_done_valid: assert property (@(posedge clk) disable iff (sys_rst)
    i_done |-> i_valid)
    else count_failure("done without a valid output");

  a_run_end: assert property (@(posedge clk) disable iff (sys_rst)
    $past(i_valid) |-> (i_valid == !$past(i_done)))
    else count_failure("valid run does not end right after done");

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic sys_rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset drops just after the last reset edge.
  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    sys_rst = 1'b0;
  end

endmodule

/* source/cb_read_top.sv */
`timescale 1ns/1ps

module cb_read_top import slam_cfg_pkg::*, cb_map_pkg::*; (
  input  logic        clk,
  input  logic        sys_rst,
  input  logic        i_wr_stb,
  input  cb_wr_t      i_wr,
  input  logic        i_cmd_stb,
  input  cb_cmd_t     i_cmd,
  output logic        o_busy,
  output logic        o_valid,
  output logic        o_done,
  output cb_map_out_t o_map
);

  logic               cnt_clr;
  logic               cnt_inc;
  logic [ROW_LEN-1:0] last_idx;
  logic [ROW_LEN-1:0] cnt_val;
  logic               cnt_last;
  logic               rd_en;
  logic [ROW_LEN-1:0] rd_addr;
  cb_row_t            rd_data;
  cb_sel_t            map_sel;
  logic               map_l_k_0;
  logic [ROW_LEN-1:0] map_pos;

  cb_bank_mem u_mem (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_wr_stb  (i_wr_stb),
    .i_wr      (i_wr),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  cb_row_counter u_cnt (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_clr      (cnt_clr),
    .i_inc      (cnt_inc),
    .i_last_idx (last_idx),
    .o_cnt      (cnt_val),
    .o_last     (cnt_last)
  );

  cb_read_fsm u_fsm (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_cmd_stb   (i_cmd_stb),
    .i_cmd       (i_cmd),
    .o_busy      (o_busy),
    .i_cnt       (cnt_val),
    .i_cnt_last  (cnt_last),
    .o_cnt_clr   (cnt_clr),
    .o_cnt_inc   (cnt_inc),
    .o_last_idx  (last_idx),
    .o_rd_en     (rd_en),
    .o_rd_addr   (rd_addr),
    .o_map_sel   (map_sel),
    .o_map_l_k_0 (map_l_k_0),
    .o_map_pos   (map_pos),
    .o_valid     (o_valid),
    .o_done      (o_done)
  );

  cb_douta_map u_map (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_sel   (map_sel),
    .i_l_k_0 (map_l_k_0),
    .i_pos   (map_pos),
    .i_row   (rd_data),
    .o_map   (o_map)
  );

endmodule

/* source/cb_douta_map.sv */
`timescale 1ns/1ps

module cb_douta_map import slam_cfg_pkg::*, cb_map_pkg::*; (
  input  logic               clk,
  input  logic               sys_rst,
  input  cb_sel_t            i_sel,
  input  logic               i_l_k_0, // low bit of the landmark index.
  input  logic [ROW_LEN-1:0] i_pos,   // row position within the run.
  input  cb_row_t            i_row,
  output cb_map_out_t        o_map
);

  // lane mapping shared by the A, B and M ports.
  function automatic cb_row_t map_operand(
    input cb_dir_e dir,
    input logic    l_k_0,
    input cb_row_t row
  );
    cb_row_t res;
    res = '0;
    case (dir)
      DIR_POS: res = row;
      DIR_NEG: begin
        for (int i = 0; i < L_LANES; i++) begin
          res[i] = row[L_LANES-1-i];
        end
      end
      DIR_NEW: begin
        // odd landmark sits in banks 0-1, even one in banks 2-3.
        res[0] = l_k_0 ? row[0] : row[2];
        res[1] = l_k_0 ? row[1] : row[3];
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  // diagonal placement of the new landmark pair into the temp buffer.
  function automatic cb_row_t map_tb(
    input cb_dir_e            dir,
    input logic               l_k_0,
    input logic [ROW_LEN-1:0] pos,
    input cb_row_t            row
  );
    logic [RSA_DW-1:0] lo;
    logic [RSA_DW-1:0] hi;
    cb_row_t           res;
    lo  = l_k_0 ? row[0] : row[2];
    hi  = l_k_0 ? row[1] : row[3];
    res = '0;
    if (dir == DIR_NEW && pos < ROW_LEN'(TB_NEW_STEPS)) begin
      case (pos)
        'd0: res[3] = hi;
        'd1: res[0] = lo;
        'd2: begin
          res[0] = hi;
          res[1] = lo;
        end
        'd3: begin
          res[1] = hi;
          res[2] = lo;
        end
        'd4: begin
          res[2] = hi;
          res[3] = lo;
        end
        default: res = '0;
      endcase
    end
    return res;
  endfunction

  // only the named port carries data, the other three read zero.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_map <= '0;
    end else begin
      o_map.tb <= (i_sel.dest == DEST_TB) ? map_tb(i_sel.dir, i_l_k_0, i_pos, i_row) : '0;
      o_map.a  <= (i_sel.dest == DEST_A) ? map_operand(i_sel.dir, i_l_k_0, i_row) : '0;
      o_map.b  <= (i_sel.dest == DEST_B) ? map_operand(i_sel.dir, i_l_k_0, i_row) : '0;
      o_map.m  <= (i_sel.dest == DEST_M) ? map_operand(i_sel.dir, i_l_k_0, i_row) : '0;
    end
  end

endmodule

/* source/cb_read_fsm.sv */
`timescale 1ns/1ps

module cb_read_fsm import slam_cfg_pkg::*, cb_map_pkg::*; (
  input  logic               clk,
  input  logic               sys_rst,

  // command strobe, dropped while busy.
  input  logic               i_cmd_stb,
  input  cb_cmd_t            i_cmd,
  output logic               o_busy,

  // row counter.
  input  logic [ROW_LEN-1:0] i_cnt,
  input  logic               i_cnt_last,
  output logic               o_cnt_clr,
  output logic               o_cnt_inc,
  output logic [ROW_LEN-1:0] o_last_idx,

  // memory read request.
  output logic               o_rd_en,
  output logic [ROW_LEN-1:0] o_rd_addr,

  // mapper controls, aligned with the read data.
  output cb_sel_t            o_map_sel,
  output logic               o_map_l_k_0,
  output logic [ROW_LEN-1:0] o_map_pos,

  // aligned with the mapper output.
  output logic               o_valid,
  output logic               o_done
);

  typedef enum logic {
    S_IDLE,
    S_READ
  } state_e;

  state_e  state;
  state_e  state_nxt;
  cb_cmd_t cmd_q;
  logic    accept;
  logic    issue;
  logic    valid_s1;
  logic    done_s1;

  assign accept = (state == S_IDLE) && i_cmd_stb;
  assign issue  = (state == S_READ); // one read per READ cycle.

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: if (accept) state_nxt = S_READ;
      S_READ: if (i_cnt_last) state_nxt = S_IDLE; // last row issued.
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= i_cmd;
    end
  end

  assign o_busy     = issue;
  assign o_cnt_clr  = accept;
  assign o_cnt_inc  = issue && !i_cnt_last;
  assign o_last_idx = i_cmd.count;
  assign o_rd_en    = issue;
  assign o_rd_addr  = cmd_q.base + i_cnt;

  // stage 1 meets the memory data, stage 2 meets the mapper output.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_map_sel <= CB_SEL_IDLE;
      valid_s1  <= 1'b0;
      done_s1   <= 1'b0;
      o_valid   <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      o_map_sel <= issue ? cmd_q.sel : CB_SEL_IDLE; // no row, no output.
      valid_s1  <= issue;
      done_s1   <= issue && i_cnt_last;
      o_valid   <= valid_s1;
      o_done    <= done_s1;
    end
  end

  always_ff @(posedge clk) begin
    o_map_l_k_0 <= cmd_q.l_k_0;
    o_map_pos   <= i_cnt; // row position within the run.
  end

endmodule

/* source/cb_row_counter.sv */
`timescale 1ns/1ps

module cb_row_counter import slam_cfg_pkg::*; (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic               i_clr,      // start of a run.
  input  logic               i_inc,      // step to the next row.
  input  logic [ROW_LEN-1:0] i_last_idx, // sampled with i_clr.
  output logic [ROW_LEN-1:0] o_cnt,
  output logic               o_last
);

  logic [ROW_LEN-1:0] last_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_cnt  <= '0;
      last_q <= '0;
    end else if (i_clr) begin
      o_cnt  <= '0;
      last_q <= i_last_idx;
    end else if (i_inc) begin
      o_cnt <= o_cnt + 1'b1;
    end
  end

  // end of run is decided here, not in the sequencer.
  assign o_last = (o_cnt == last_q);

endmodule

/* source/cb_bank_mem.sv */
`timescale 1ns/1ps

module cb_bank_mem import slam_cfg_pkg::*, cb_map_pkg::*; (
  input  logic               clk,
  input  logic               sys_rst,

  // load port, written on the same edge.
  input  logic               i_wr_stb,
  input  cb_wr_t             i_wr,

  // read port, one cycle latency.
  input  logic               i_rd_en,
  input  logic [ROW_LEN-1:0] i_rd_addr,
  output cb_row_t            o_rd_data
);

  // one bank per lane, all banks share the row address.
  logic [RSA_DW-1:0] bank [L_LANES][CB_DEPTH];

  always_ff @(posedge clk) begin
    if (i_wr_stb) begin
      for (int b = 0; b < L_LANES; b++) begin
        bank[b][i_wr.addr] <= i_wr.row[b];
      end
    end
  end

  // read register keeps the last row between reads.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      for (int b = 0; b < L_LANES; b++) begin
        o_rd_data[b] <= bank[b][i_rd_addr]; // lane b comes from bank b.
      end
    end
  end

endmodule

/* source/cb_map_pkg.sv */
package cb_map_pkg;

  import slam_cfg_pkg::*;

  // destination port of a CB row.
  typedef enum logic [1:0] {
    DEST_TB = 2'b00, // temp buffer write data.
    DEST_A  = 2'b01,
    DEST_B  = 2'b10,
    DEST_M  = 2'b11
  } cb_dest_e;

  // lane mapping applied on the way out.
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00,
    DIR_POS  = 2'b01, // lanes straight.
    DIR_NEG  = 2'b10, // lanes reversed.
    DIR_NEW  = 2'b11  // new-landmark pair, picked by l_k_0.
  } cb_dir_e;

  typedef struct packed {
    cb_dest_e dest;
    cb_dir_e  dir;
  } cb_sel_t;

  // select word carried by stages with no row.
  localparam cb_sel_t CB_SEL_IDLE = '{dest: DEST_TB, dir: DIR_IDLE};

  typedef logic [L_LANES-1:0][RSA_DW-1:0] cb_row_t;
  typedef logic [X_DIM-1:0][RSA_DW-1:0]   cb_xvec_t;
  typedef logic [Y_DIM-1:0][RSA_DW-1:0]   cb_yvec_t;

  typedef struct packed {
    cb_sel_t            sel;
    logic               l_k_0;
    logic [ROW_LEN-1:0] base;  // first row of the run.
    logic [ROW_LEN-1:0] count; // rows minus one.
  } cb_cmd_t;

  typedef struct packed {
    logic [ROW_LEN-1:0] addr;
    cb_row_t            row;
  } cb_wr_t;

  typedef struct packed {
    cb_xvec_t tb;
    cb_xvec_t a;
    cb_yvec_t b;
    cb_xvec_t m;
  } cb_map_out_t;

endpackage

/* source/slam_cfg_pkg.sv */
package slam_cfg_pkg;

  // lane counts of the RSA ports and of one CB row.
  localparam int X_DIM   = 4; // A, M and TB ports.
  localparam int Y_DIM   = 4; // B port.
  localparam int L_LANES = 4; // banks per CB row.

  // element width of one lane.
  localparam int RSA_DW = 16;

  // row address width, also used for run lengths.
  localparam int ROW_LEN  = 10;
  localparam int CB_DEPTH = 1024;

  // row positions covered by the TB new-landmark placement.
  localparam int TB_NEW_STEPS = 5;

endpackage
